//--- src/br_pkg.sv
// Branch resolution shared types: opcodes, condition codes, instruction views, stage records
package br_pkg;

	// Opcode anchors of the branch groups
	localparam logic [5:0] OP_JMP_GRP   = 6'h1A;	// JMP, JSR, RET, JSR_CO
	localparam logic [5:0] OP_BR        = 6'h30;	// Unconditional branch
	localparam logic [5:0] OP_BSR       = 6'h34;	// Branch to subroutine
	localparam logic [5:0] OP_COND_BASE = 6'h38;	// First conditional opcode

	// Low two bits pick the test, bit 2 inverts it
	typedef enum logic [2:0] {
		BLBC = 3'b000,	// Low bit clear
		BEQ  = 3'b001,	// Zero
		BLT  = 3'b010,	// Sign set
		BLE  = 3'b011,	// Sign set or zero
		BLBS = 3'b100,	// Low bit set
		BNE  = 3'b101,	// Nonzero
		BGE  = 3'b110,	// Sign clear
		BGT  = 3'b111	// Sign clear and nonzero
	} br_cond_e;

	typedef enum logic [1:0] {
		NONE   = 2'd0,	// Not a branch
		JUMP   = 2'd1,	// Register indirect
		UNCOND = 2'd2,	// PC relative, always taken
		COND   = 2'd3	// PC relative, tested on Ra
	} br_class_e;

	// Branch format word
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  ra;
		logic [20:0] disp;	// Signed word displacement
	} br_fmt_t;

	// Jump format word
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  ra;
		logic [4:0]  rb;	// Holds the target address
		logic [1:0]  kind;	// JMP/JSR/RET/JSR_CO
		logic [13:0] hint;	// Predictor hint bits
	} jmp_fmt_t;

	// Same 32 bits seen as either format
	typedef union packed {
		br_fmt_t  br;
		jmp_fmt_t jmp;
	} br_inst_u;

	// Issued branch as it leaves the reservation station
	typedef struct packed {
		br_inst_u    inst;
		logic [63:0] npc;
		logic [63:0] opa;	// Ra value
		logic [63:0] opb;	// Rb value
		logic        pred_taken;
		logic [63:0] pred_target;
	} br_issue_t;

	// Decode stage record
	typedef struct packed {
		br_class_e   cls;
		br_cond_e    cond;
		logic [63:0] disp;	// Sign extended, byte aligned
		logic [63:0] npc;
		logic [63:0] opa;
		logic [63:0] opb;
		logic        pred_taken;
		logic [63:0] pred_target;
	} br_dec_t;

	// Outcome of the execute logic
	typedef struct packed {
		logic        taken;
		logic        is_cond;
		logic [63:0] target;
		logic [63:0] npc;
		logic        pred_taken;
		logic [63:0] pred_target;
	} br_exec_t;

	// Record handed to the reorder buffer
	typedef struct packed {
		logic        taken;
		logic        is_cond;
		logic        mispredict;
		logic [63:0] recovery_target;	// Fetch restart address
		logic [63:0] pc;
	} br_resolve_t;

endpackage

//--- src/br_decode.sv
// Branch decode stage: classifies the opcode, extracts condition and displacement, registers them
`timescale 1ns/100ps

module br_decode #(
	parameter int ROB_IDX_W = 5	// MSB of the ROB index
)(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start_i,	// One branch this cycle
	input  br_pkg::br_issue_t     issue_i,
	input  logic [ROB_IDX_W:0]    rob_idx_i,
	output logic                  valid_o,
	output br_pkg::br_dec_t       dec_o,
	output logic [ROB_IDX_W:0]    rob_idx_o
);

	br_pkg::br_inst_u  inst;
	logic [5:0]        op_br_view;	// Opcode read as branch format
	logic [5:0]        op_jmp_view;	// Opcode read as jump format
	br_pkg::br_class_e cls_nxt;
	br_pkg::br_cond_e  cond_nxt;
	logic [63:0]       disp_nxt;
	br_pkg::br_dec_t   dec_nxt;

	assign inst        = issue_i.inst;
	assign op_br_view  = inst.br.opcode;
	assign op_jmp_view = inst.jmp.opcode;

	// Class by the top three opcode bits
	always_comb
	begin
		if (op_jmp_view[5:3] == br_pkg::OP_JMP_GRP[5:3])
			cls_nxt = br_pkg::JUMP;	// 0x18..0x1F
		else if (op_br_view[5:3] == br_pkg::OP_COND_BASE[5:3])
			cls_nxt = br_pkg::COND;	// 0x38..0x3F
		else if (op_br_view[5:3] == br_pkg::OP_BR[5:3])
			cls_nxt = br_pkg::UNCOND;	// BR, BSR and FP group
		else
			cls_nxt = br_pkg::NONE;
	end

	// Condition lives in the low opcode bits, only meaningful for COND
	assign cond_nxt = br_pkg::br_cond_e'(op_br_view[2:0]);

	// Word displacement to byte offset
	assign disp_nxt = {{41{inst.br.disp[20]}}, inst.br.disp, 2'b00};

	always_comb
	begin
		dec_nxt             = '0;
		dec_nxt.cls         = cls_nxt;
		dec_nxt.cond        = cond_nxt;
		dec_nxt.disp        = disp_nxt;
		dec_nxt.npc         = issue_i.npc;
		dec_nxt.opa         = issue_i.opa;	// Tested operand
		dec_nxt.opb         = issue_i.opb;	// Jump target source
		dec_nxt.pred_taken  = issue_i.pred_taken;
		dec_nxt.pred_target = issue_i.pred_target;
	end

	// Record only loads on start so an idle stage holds its last branch
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_o   <= 1'b0;
			dec_o     <= '0;
			rob_idx_o <= '0;
		end
		else
		begin
			valid_o <= start_i;
			if (start_i)
			begin
				dec_o     <= dec_nxt;
				rob_idx_o <= rob_idx_i;	// Travels with its branch
			end
		end
	end

endmodule

//--- src/br_execute.sv
// Branch execute logic: evaluates the condition on Ra and forms the branch target
`timescale 1ns/100ps

module br_execute (
	input  br_pkg::br_dec_t  dec_i,
	output br_pkg::br_exec_t exe_o
);

	logic        base_test;	// Test before inversion
	logic        cond_true;	// Condition outcome
	logic        opa_zero;
	logic        opa_neg;
	logic        taken_nxt;
	logic [63:0] target_nxt;
	logic [63:0] rel_target;	// PC relative destination

	assign opa_zero = (dec_i.opa == 64'd0);
	assign opa_neg  = dec_i.opa[63];	// Sign bit

	// Four base tests, selected by cond[1:0]
	always_comb
	begin
		case (dec_i.cond[1:0])
			2'b00: base_test = ~dec_i.opa[0];	// LBC
			2'b01: base_test = opa_zero;	// EQ
			2'b10: base_test = opa_neg;	// LT
			2'b11: base_test = opa_neg | opa_zero;	// LE
			default: base_test = 1'b0;
		endcase
	end

	// Bit 2 flips the sense: LBS, NE, GE, GT
	assign cond_true = dec_i.cond[2] ? ~base_test : base_test;

	// Direction by class
	always_comb
	begin
		case (dec_i.cls)
			br_pkg::JUMP:   taken_nxt = 1'b1;
			br_pkg::UNCOND: taken_nxt = 1'b1;
			br_pkg::COND:   taken_nxt = cond_true;
			default:        taken_nxt = 1'b0;	// Not a branch
		endcase
	end

	assign rel_target = dec_i.npc + dec_i.disp;

	// Destination by class
	always_comb
	begin
		case (dec_i.cls)
			br_pkg::JUMP:
			begin
				target_nxt = {dec_i.opb[63:2], 2'b00};	// Rb, word aligned
			end
			br_pkg::UNCOND, br_pkg::COND:
			begin
				target_nxt = rel_target;
			end
			default:
			begin
				target_nxt = dec_i.npc;	// Falls through
			end
		endcase
	end

	always_comb
	begin
		exe_o             = '0;
		exe_o.taken       = taken_nxt;
		exe_o.is_cond     = (dec_i.cls == br_pkg::COND);	// Predictor update flag
		exe_o.target      = target_nxt;
		exe_o.npc         = dec_i.npc;
		exe_o.pred_taken  = dec_i.pred_taken;
		exe_o.pred_target = dec_i.pred_target;
	end

endmodule

//--- src/br_result.sv
// Branch result stage: checks the prediction and registers the recovery record for the ROB
`timescale 1ns/100ps

module br_result #(
	parameter int ROB_IDX_W = 5	// MSB of the ROB index
)(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  valid_i,	// Decode stage holds a new branch
	input  br_pkg::br_exec_t      exe_i,
	input  logic [ROB_IDX_W:0]    rob_idx_i,
	output logic                  done_o,
	output logic [ROB_IDX_W:0]    rob_idx_o,
	output br_pkg::br_resolve_t   resolve_o
);

	logic                dir_wrong;	// Direction differs from prediction
	logic                tgt_wrong;	// Taken to a different address
	logic                mispredict_nxt;
	logic [63:0]         recovery_nxt;
	br_pkg::br_resolve_t resolve_nxt;

	assign dir_wrong = (exe_i.taken != exe_i.pred_taken);

	// Target only matters when the branch goes
	assign tgt_wrong = exe_i.taken && (exe_i.target != exe_i.pred_target);

	// Idle cycles never flag recovery
	assign mispredict_nxt = valid_i && (dir_wrong || tgt_wrong);

	// Restart at target if taken, else at the fall-through
	assign recovery_nxt = exe_i.taken ? exe_i.target : exe_i.npc;

	always_comb
	begin
		resolve_nxt                 = '0;
		resolve_nxt.taken           = exe_i.taken;
		resolve_nxt.is_cond         = exe_i.is_cond;
		resolve_nxt.mispredict      = mispredict_nxt;
		resolve_nxt.recovery_target = recovery_nxt;
		resolve_nxt.pc              = exe_i.npc;	// Reported PC is the npc
	end

	// Strobe, index and record leave on the same edge
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			done_o    <= 1'b0;
			rob_idx_o <= '0;
			resolve_o <= '0;
		end
		else
		begin
			done_o    <= valid_i;
			rob_idx_o <= rob_idx_i;
			resolve_o <= resolve_nxt;
		end
	end

endmodule

//--- src/br_unit_top.sv
// Branch resolution unit top: decode, execute and result stages chained into a two-edge pipe
`timescale 1ns/100ps

module br_unit_top #(
	parameter int ROB_IDX_W = 5	// MSB of the ROB index
)(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start_i,	// Issue strobe
	input  br_pkg::br_issue_t     issue_i,
	input  logic [ROB_IDX_W:0]    rob_idx_i,
	output logic                  done_o,	// Result strobe, two edges later
	output logic [ROB_IDX_W:0]    rob_idx_o,
	output br_pkg::br_resolve_t   resolve_o
);

	logic                 dec_valid;
	br_pkg::br_dec_t      dec;	// Registered decode record
	logic [ROB_IDX_W:0]   dec_rob_idx;
	br_pkg::br_exec_t     exe;	// Combinational execute outcome

	// Stage 1
	br_decode #(
		.ROB_IDX_W (ROB_IDX_W)
	) u_decode (
		.clk       (clk),
		.rst       (rst),
		.start_i   (start_i),
		.issue_i   (issue_i),
		.rob_idx_i (rob_idx_i),
		.valid_o   (dec_valid),
		.dec_o     (dec),
		.rob_idx_o (dec_rob_idx)
	);

	// Between the two registers
	br_execute u_execute (
		.dec_i (dec),
		.exe_o (exe)
	);

	// Stage 2
	br_result #(
		.ROB_IDX_W (ROB_IDX_W)
	) u_result (
		.clk       (clk),
		.rst       (rst),
		.valid_i   (dec_valid),
		.exe_i     (exe),
		.rob_idx_i (dec_rob_idx),
		.done_o    (done_o),
		.rob_idx_o (rob_idx_o),
		.resolve_o (resolve_o)
	);

endmodule

//--- sim/br_unit_checker.sv
// Branch unit protocol checker: strobe latency, ROB index transport and mispredict qualification
`timescale 1ns/100ps

module br_unit_checker #(
	parameter int ROB_IDX_W = 5
)(
	input  logic               clk,
	input  logic               rst,
	input  logic               start_i,
	input  logic [ROB_IDX_W:0] rob_idx_i,
	input  logic               done_i,	// DUT done_o
	input  logic [ROB_IDX_W:0] rob_out_i,	// DUT rob_idx_o
	input  logic               mispredict_i
);

	int unsigned fail_cnt = 0;	// Read by the testbench at the end

	// Reset edge clears the strobe
	a_rst_quiet: assert property (@(posedge clk) rst |=> !done_i)
		else begin fail_cnt++; $error("done_o high after a reset edge"); end

	// Fixed two-edge pipe, one result per start
	a_latency: assert property (@(posedge clk) disable iff (rst) done_i == $past(start_i, 2))
		else begin fail_cnt++; $error("done_o does not follow start_i by two edges"); end

	a_rob_idx: assert property (@(posedge clk) disable iff (rst)
		done_i |-> rob_out_i == $past(rob_idx_i, 2))
		else begin fail_cnt++; $error("rob_idx_o lost its branch"); end

	// Recovery only alongside a result
	a_mispredict: assert property (@(posedge clk) mispredict_i |-> done_i)
		else begin fail_cnt++; $error("mispredict without done_o"); end

endmodule

bind br_unit_top br_unit_checker #(
	.ROB_IDX_W (ROB_IDX_W)
) u_checker (
	.clk          (clk),
	.rst          (rst),
	.start_i      (start_i),
	.rob_idx_i    (rob_idx_i),
	.done_i       (done_o),
	.rob_out_i    (rob_idx_o),
	.mispredict_i (resolve_o.mispredict)
);

//--- sim/br_unit_tb.sv
// Branch resolution unit testbench: directed and random branches against a reference model
`timescale 1ns/100ps

module br_unit_tb;

	localparam int ROB_IDX_W   = 5;
	localparam int TIMEOUT_CYC = 20;	// Longest wait for any result

	typedef struct packed {
		br_pkg::br_resolve_t res;
		logic [ROB_IDX_W:0]  rob;
		logic [31:0]         cyc;	// Cycle in which done_o is due
	} exp_t;

	logic                clk;
	logic                rst;
	logic                start_i;
	br_pkg::br_issue_t   issue_i;
	logic [ROB_IDX_W:0]  rob_idx_i;
	logic                done_o;
	logic [ROB_IDX_W:0]  rob_idx_o;
	br_pkg::br_resolve_t resolve_o;

	exp_t        exp_q[$];	// In issue order
	int unsigned errors = 0;
	int unsigned checks = 0;
	logic [31:0] cyc = '0;	// Rising edges seen

	br_unit_top #(
		.ROB_IDX_W (ROB_IDX_W)
	) DUT (
		.clk       (clk),
		.rst       (rst),
		.start_i   (start_i),
		.issue_i   (issue_i),
		.rob_idx_i (rob_idx_i),
		.done_o    (done_o),
		.rob_idx_o (rob_idx_o),
		.resolve_o (resolve_o)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;	// 20 ns period
	always @(posedge clk) cyc <= cyc + 32'd1;

	// Expected record straight from the branch rules
	function automatic br_pkg::br_resolve_t br_model(br_pkg::br_issue_t iss);
		br_pkg::br_resolve_t r;
		logic [5:0]  op;
		logic [63:0] disp;
		logic [63:0] tgt;
		logic        t;
		op   = iss.inst.br.opcode;
		disp = {{43{iss.inst.br.disp[20]}}, iss.inst.br.disp} << 2;	// Words to bytes
		t    = 1'b0;
		tgt  = iss.npc;
		if (op >= 6'h18 && op <= 6'h1F)
		begin
			t   = 1'b1;
			tgt = iss.opb & ~64'd3;	// Register jump
		end
		else if (op >= 6'h30 && op <= 6'h37)
		begin
			t   = 1'b1;
			tgt = iss.npc + disp;
		end
		else if (op >= 6'h38)
		begin
			case (op[2:0])
				3'd0: t = (iss.opa[0] == 1'b0);	// BLBC
				3'd1: t = (iss.opa == 64'd0);	// BEQ
				3'd2: t = ($signed(iss.opa) < 64'sd0);
				3'd3: t = ($signed(iss.opa) <= 64'sd0);
				3'd4: t = iss.opa[0];	// BLBS
				3'd5: t = (iss.opa != 64'd0);
				3'd6: t = ($signed(iss.opa) >= 64'sd0);
				default: t = ($signed(iss.opa) > 64'sd0);	// BGT
			endcase
			tgt = iss.npc + disp;
		end
		r                 = '0;
		r.taken           = t;
		r.is_cond         = (op >= 6'h38);
		r.mispredict      = (t != iss.pred_taken) || (t && tgt != iss.pred_target);
		r.recovery_target = t ? tgt : iss.npc;
		r.pc              = iss.npc;
		return r;
	endfunction

	function automatic br_pkg::br_issue_t make_issue(logic [5:0] op, logic [20:0] disp,
		logic [63:0] npc, logic [63:0] opa, logic [63:0] opb, logic pt, logic [63:0] ptgt);
		br_pkg::br_issue_t iss;
		iss                  = '0;
		iss.inst.br.opcode   = op;
		iss.inst.br.ra       = 5'd3;
		iss.inst.br.disp     = disp;	// Also rb, kind and hint for jumps
		iss.npc              = npc;
		iss.opa              = opa;
		iss.opb              = opb;
		iss.pred_taken       = pt;
		iss.pred_target      = ptgt;
		return iss;
	endfunction

	// Mostly conditional opcodes, rest anything
	function automatic br_pkg::br_issue_t random_issue();
		br_pkg::br_issue_t   iss;
		br_pkg::br_resolve_t r;
		logic [31:0]         a;
		logic [31:0]         b;
		logic [5:0]          op;
		a   = $urandom();
		b   = $urandom();
		op  = a[0] ? {3'b111, a[3:1]} : a[9:4];
		iss = make_issue(op, a[30:10], {b, a[31:2], 2'b00}, {$urandom(), $urandom()},
			{$urandom(), $urandom()}, b[0], {$urandom(), $urandom()});
		if (b[3:2] == 2'b00)
			iss.opa = 64'd0;	// Hit the zero tests too
		r = br_model(iss);
		if (b[1])
			iss.pred_target = r.recovery_target;
		return iss;
	endfunction

	task automatic check_val(string name, logic [63:0] exp, logic [63:0] act);
		checks++;
		assert (act === exp)
		else
		begin
			errors++;
			$display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	// Drive 2 ns after the edge, remember what must come back
	task automatic send(br_pkg::br_issue_t iss, logic [ROB_IDX_W:0] rob);
		exp_t e;
		@(posedge clk);
		#2;
		start_i   = 1'b1;
		issue_i   = iss;
		rob_idx_i = rob;
		e.res     = br_model(iss);
		e.rob     = rob;
		e.cyc     = cyc + 32'd2;
		exp_q.push_back(e);
	endtask

	task automatic idle();
		@(posedge clk);
		#2;
		start_i = 1'b0;
	endtask

	task automatic drain();
		int unsigned w;
		w = 0;
		while (exp_q.size() != 0 && w < TIMEOUT_CYC)
		begin
			@(negedge clk);
			w++;
		end
		assert (exp_q.size() == 0)
		else
		begin
			errors++;
			$display("Results still outstanding %0d cycles after the last start", TIMEOUT_CYC);
		end
	endtask

	// Outputs settle long before the falling edge
	always @(negedge clk)
	begin : compare
		exp_t e;
		if (!rst)
		begin
			assert (done_o || !resolve_o.mispredict)
			else
			begin
				errors++;
				$display("Mispredict raised without done_o at %0t", $time);
			end
			if (exp_q.size() != 0 && cyc > exp_q[0].cyc + TIMEOUT_CYC - 2)
			begin
				errors++;
				$display("Result for ROB index %0d never arrived", exp_q[0].rob);
				void'(exp_q.pop_front());
			end
			if (done_o)
			begin
				assert (exp_q.size() != 0)
				else
				begin
					errors++;
					$display("done_o pulsed at %0t with no branch outstanding", $time);
				end
				if (exp_q.size() != 0)
				begin
					e = exp_q.pop_front();
					check_val("done_o cycle", e.cyc, cyc);	// Two edges after start
					check_val("rob_idx_o", e.rob, rob_idx_o);
					check_val("resolve_o.taken", e.res.taken, resolve_o.taken);
					check_val("resolve_o.is_cond", e.res.is_cond, resolve_o.is_cond);
					check_val("resolve_o.mispredict", e.res.mispredict, resolve_o.mispredict);
					check_val("resolve_o.recovery_target", e.res.recovery_target,
						resolve_o.recovery_target);
					check_val("resolve_o.pc", e.res.pc, resolve_o.pc);
				end
			end
		end
	end

	initial
	begin
		logic [63:0]        ra_vals [5];
		logic [ROB_IDX_W:0] rob;
		logic [31:0]        rnd;
		void'($urandom(32'h2259d908));
		rst       = 1'b1;
		start_i   = 1'b0;
		issue_i   = '0;
		rob_idx_i = '0;
		rob       = '0;
		ra_vals   = '{64'd0, 64'd7, 64'd6, 64'h8000_0000_0000_0000, '1};
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;

		// Quiet pipe after reset
		repeat (4)
		begin
			@(negedge clk);
			check_val("done_o", 64'd0, done_o);
			check_val("resolve_o any bit", 64'd0, |resolve_o);
		end

		// All conditions against the corner Ra values, both displacement signs
		for (int c = 0; c < 8; c++)
		begin
			for (int k = 0; k < 5; k++)
			begin
				send(make_issue(6'h38 + c[5:0], k[0] ? 21'h1F_FFF0 : 21'h00_0040,
					64'h4000 + {56'd0, c[3:0], k[3:0]}, ra_vals[k], 64'd0, 1'b0, 64'd0), rob);
				rob++;
			end
		end
		idle();
		drain();

		// Unconditional, FP group, jumps and non-branches
		send(make_issue(br_pkg::OP_BR, 21'h00_0100, 64'h1000, 64'd0, 64'd0, 1'b1, 64'd0), rob);
		send(make_issue(br_pkg::OP_BSR, 21'h1F_FF00, 64'h9000, 64'd1, 64'd0, 1'b0, 64'd0), rob);
		send(make_issue(6'h33, 21'h00_0004, 64'h2000, 64'd0, 64'd0, 1'b1, 64'h2010), rob);
		send(make_issue(br_pkg::OP_JMP_GRP, 21'h0, 64'h3000, 64'd0, 64'h1237, 1'b1, 64'h1234), rob);
		send(make_issue(6'h18, 21'h0, 64'h3000, 64'd0, '1, 1'b0, 64'd0), rob);
		send(make_issue(6'h1F, 21'h0, 64'h3000, 64'd0, 64'h8000_0000_0000_0002, 1'b1, 64'd0), rob);
		send(make_issue(6'h10, 21'h00_0040, 64'h5000, 64'd0, 64'd0, 1'b0, 64'd0), rob);
		send(make_issue(6'h2C, 21'h00_0040, 64'h5004, 64'd0, 64'd0, 1'b1, 64'h5104), rob);
		idle();
		drain();

		// Prediction cases on BEQ, target 0x2100 when taken
		send(make_issue(6'h39, 21'h40, 64'h2000, 64'd0, 64'd0, 1'b1, 64'h2100), 6'd1);
		send(make_issue(6'h39, 21'h40, 64'h2000, 64'd0, 64'd0, 1'b0, 64'h2100), 6'd2);
		send(make_issue(6'h39, 21'h40, 64'h2000, 64'd0, 64'd0, 1'b1, 64'h2104), 6'd3);
		send(make_issue(6'h39, 21'h40, 64'h2000, 64'd5, 64'd0, 1'b0, 64'hDEAD), 6'd4);
		send(make_issue(6'h39, 21'h40, 64'h2000, 64'd5, 64'd0, 1'b1, 64'h2000), 6'd5);
		idle();
		drain();

		// Back to back random branches
		repeat (40)
		begin
			rnd = $urandom();
			send(random_issue(), rnd[ROB_IDX_W:0]);
		end
		idle();
		drain();

		// Gapped start strobe
		repeat (60)
		begin
			rnd = $urandom();
			if (rnd[0])
				send(random_issue(), rnd[ROB_IDX_W+1:1]);
			else
				idle();
		end
		idle();
		drain();
		repeat (4) @(negedge clk);	// Catch any stray done_o

		$display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
			DUT.u_checker.fail_cnt);
		if (errors == 0 && DUT.u_checker.fail_cnt == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- sources.f
src/br_pkg.sv
src/br_decode.sv
src/br_execute.sv
src/br_result.sv
src/br_unit_top.sv
sim/br_unit_checker.sv
sim/br_unit_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := br_unit_tb
FILELIST   := sources.f
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
